/* design/lsq_defs.svh */
/*
 * Sizing macros for the load/store buffer
 * Entry count, ROB tag width, data width and data RAM depth
 */
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// Buffer entries, index value equal to this means none
`define LSQ_ENTRIES 7

// ROB tag width, tag 0 marks a present operand
`define LSQ_TAG_W 4

`define LSQ_XLEN 32

// Data RAM depth in words
`define LSQ_DMEM_WORDS 64

`endif

/* design/lsq_pkg.sv */
/*
 * Shared types of the load/store subsystem
 * Instruction views, operand and buffer entry records,
 * CDB, load request, store commit and result records, opcode and funct3 codes
 */
`default_nettype none
`include "lsq_defs.svh"

package lsq_pkg;
    typedef logic [`LSQ_XLEN-1:0]  word_t;
    typedef logic [`LSQ_TAG_W-1:0] tag_t;

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam logic [2:0] lb  = 3'b000;
    localparam logic [2:0] lh  = 3'b001;
    localparam logic [2:0] lw  = 3'b010;
    localparam logic [2:0] lbu = 3'b100;
    localparam logic [2:0] lhu = 3'b101;
    localparam logic [2:0] sb  = 3'b000;
    localparam logic [2:0] sh  = 3'b001;
    localparam logic [2:0] sw  = 3'b010;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i;   // Loads
        s_fmt_t s;   // Stores
    } mem_instr_u;

    typedef struct packed {
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic       valid;
        mem_instr_u instr;
        operand_t   base;
        operand_t   data;
        tag_t       dest;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        logic     is_store;
        logic [2:0] funct3;
        word_t    imm;       // Already sign extended
        operand_t base;
        operand_t data;
        tag_t     dest;
    } lsb_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        logic [2:0] funct3;
        tag_t       tag;
    } load_req_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        word_t      data;
        logic [2:0] funct3;
    } store_commit_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t addr;
        word_t data;
    } lsb_result_t;

    // Capture a broadcast value into a waiting operand
    function automatic operand_t cdb_snoop(operand_t op, cdb_t c);
        operand_t r;
        r = op;
        if (c.valid && op.tag != '0 && op.tag == c.tag) begin
            r.tag   = '0;
            r.value = c.value;
        end
        return r;
    endfunction
endpackage

`default_nettype wire

/* design/lsb_dispatch.sv */
/*
 * Dispatch stage for loads and stores
 * Decodes the I or S view of the word, one register stage, CDB snoop while held
 */
`default_nettype none
`include "lsq_defs.svh"

module lsb_dispatch import lsq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  dispatch_t  disp,
    output logic       dispatch_ready,
    input  cdb_t       cdb,
    output lsb_entry_t entry,
    input  logic       entry_ready
);
    mem_instr_u ins;
    lsb_entry_t dec;
    lsb_entry_t held;
    logic       live;   // Low during the first cycle out of reset

    assign ins = disp.instr;

    always_comb begin
        dec.is_store = (ins.s.opcode == op_store);
        dec.valid    = disp.valid && (dec.is_store || ins.i.opcode == op_load);
        dec.funct3   = ins.i.funct3;   // Same bits in both views
        if (dec.is_store) begin
            dec.imm = {{(`LSQ_XLEN-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
        end else begin
            dec.imm = {{(`LSQ_XLEN-12){ins.i.imm[11]}}, ins.i.imm};
        end
        dec.base = cdb_snoop(disp.base, cdb);
        dec.data = cdb_snoop(disp.data, cdb);
        dec.dest = disp.dest;
    end

    assign dispatch_ready = live && (!held.valid || entry_ready);
    assign entry          = held;

    always_ff @(posedge clk) begin
        live <= !rst;
        if (rst || flush) begin
            held.valid <= 1'b0;
        end else if (dispatch_ready) begin
            held <= dec;
        end else begin
            held.base <= cdb_snoop(held.base, cdb);   // Waiting on back-pressure
            held.data <= cdb_snoop(held.data, cdb);
        end
    end
endmodule

`default_nettype wire

/* design/lsb_rs.sv */
/*
 * Load/store reservation station
 * Priority free-entry pick, operand capture from the CDB,
 * uncommitted store count per load, lowest-index load issue, store completion
 */
`default_nettype none
`include "lsq_defs.svh"

module lsb_rs import lsq_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  lsb_entry_t  entry,
    output logic        entry_ready,
    input  cdb_t        cdb,
    input  logic        commit_fire,
    output load_req_t   load_req,
    input  logic        load_ready,
    output lsb_result_t store_res
);
    localparam int N  = `LSQ_ENTRIES;
    localparam int IW = $clog2(`LSQ_ENTRIES + 1);
    localparam logic [IW-1:0] NONE = IW'(N);

    lsb_entry_t            ent   [N];
    logic [`LSQ_TAG_W-1:0] older [N];   // Uncommitted stores ahead of each load
    logic [`LSQ_TAG_W-1:0] store_cnt;
    logic [IW-1:0]         free_idx;
    logic [IW-1:0]         load_idx;
    logic [IW-1:0]         st_idx;
    lsb_result_t           st_next;
    logic                  push;
    logic                  push_store;
    logic                  load_fire;
    logic                  cnt_dec;

    always_comb begin
        free_idx = NONE;
        for (int i = N - 1; i >= 0; i--) begin
            if (!ent[i].valid) free_idx = IW'(i);
        end
    end

    assign entry_ready = (free_idx != NONE);
    assign push        = entry.valid && entry_ready;
    assign push_store  = push && entry.is_store;
    assign cnt_dec     = commit_fire && store_cnt != '0;

    // Lowest index eligible load wins
    always_comb begin
        load_idx = NONE;
        load_req = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (ent[i].valid && !ent[i].is_store && ent[i].base.tag == '0 &&
                older[i] == '0) begin
                load_idx        = IW'(i);
                load_req.valid  = 1'b1;
                load_req.addr   = ent[i].base.value + ent[i].imm;
                load_req.funct3 = ent[i].funct3;
                load_req.tag    = ent[i].dest;
            end
        end
    end

    assign load_fire = load_req.valid && load_ready;

    // One store completes per cycle
    always_comb begin
        st_idx  = NONE;
        st_next = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (ent[i].valid && ent[i].is_store && ent[i].base.tag == '0 &&
                ent[i].data.tag == '0) begin
                st_idx        = IW'(i);
                st_next.valid = 1'b1;
                st_next.tag   = ent[i].dest;
                st_next.addr  = ent[i].base.value + ent[i].imm;
                st_next.data  = ent[i].data.value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            store_cnt <= '0;
        end else if (push_store && !cnt_dec) begin
            store_cnt <= store_cnt + 1'b1;
        end else if (cnt_dec && !push_store) begin
            store_cnt <= store_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (rst || flush) begin
                ent[i].valid <= 1'b0;
            end else if (push && free_idx == IW'(i)) begin
                ent[i]      <= entry;
                ent[i].base <= cdb_snoop(entry.base, cdb);
                ent[i].data <= cdb_snoop(entry.data, cdb);
                older[i]    <= cnt_dec ? store_cnt - 1'b1 : store_cnt;
            end else begin
                if ((load_fire && load_idx == IW'(i)) || st_idx == IW'(i)) begin
                    ent[i].valid <= 1'b0;
                end
                ent[i].base <= cdb_snoop(ent[i].base, cdb);
                ent[i].data <= cdb_snoop(ent[i].data, cdb);
                if (commit_fire && older[i] != '0) older[i] <= older[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            store_res.valid <= 1'b0;
        end else begin
            store_res <= st_next;
        end
    end
endmodule

`default_nettype wire

/* design/lsb_mem_port.sv */
/*
 * APB master for the load/store buffer
 * Commit register, store strobes and lane shift,
 * load lane select with sign or zero extension, flush drop flag
 */
`default_nettype none
`include "lsq_defs.svh"

module lsb_mem_port import lsq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  load_req_t     load_req,
    output logic          load_ready,
    input  store_commit_t commit,
    output logic          commit_ready,
    output logic          psel,
    output logic          penable,
    output logic          pwrite,
    output word_t         paddr,
    output word_t         pwdata,
    output logic [3:0]    pstrb,
    input  logic          pready,
    input  word_t         prdata,
    output lsb_result_t   load_res
);
    typedef enum logic [1:0] {st_idle, st_setup, st_access} state_t;

    state_t        state;
    store_commit_t cm;        // Accepted commit, waits for the bus
    word_t         ld_addr;
    logic [2:0]    ld_f3;
    tag_t          ld_tag;
    logic          drop;      // Flushed load still on the bus
    word_t         lane;
    word_t         ld_data;
    logic [3:0]    st_strb;

    assign psel         = (state != st_idle);
    assign penable      = (state == st_access);
    assign commit_ready = !cm.valid;
    assign load_ready   = (state == st_idle) && !cm.valid;

    always_comb begin
        case (cm.funct3)
            sb:      st_strb = 4'b0001 << cm.addr[1:0];
            sh:      st_strb = cm.addr[1] ? 4'b1100 : 4'b0011;
            sw:      st_strb = 4'b1111;
            default: st_strb = 4'b0000;
        endcase
    end

    assign lane = prdata >> {ld_addr[1:0], 3'b000};

    always_comb begin
        case (ld_f3)
            lb:      ld_data = {{(`LSQ_XLEN-8){lane[7]}}, lane[7:0]};
            lbu:     ld_data = {{(`LSQ_XLEN-8){1'b0}}, lane[7:0]};
            lh:      ld_data = {{(`LSQ_XLEN-16){lane[15]}}, lane[15:0]};
            lhu:     ld_data = {{(`LSQ_XLEN-16){1'b0}}, lane[15:0]};
            lw:      ld_data = prdata;
            default: ld_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= st_idle;
            cm.valid       <= 1'b0;
            load_res.valid <= 1'b0;
            drop           <= 1'b0;
        end else begin
            load_res.valid <= 1'b0;
            if (commit.valid && commit_ready) cm <= commit;
            case (state)
                st_idle: begin
                    if (cm.valid) begin   // Commit before any load
                        state  <= st_setup;
                        pwrite <= 1'b1;
                        paddr  <= {cm.addr[`LSQ_XLEN-1:2], 2'b00};
                        pwdata <= cm.data << {cm.addr[1:0], 3'b000};
                        pstrb  <= st_strb;
                    end else if (load_req.valid) begin
                        state   <= st_setup;
                        pwrite  <= 1'b0;
                        paddr   <= {load_req.addr[`LSQ_XLEN-1:2], 2'b00};
                        pstrb   <= 4'b0000;
                        ld_addr <= load_req.addr;
                        ld_f3   <= load_req.funct3;
                        ld_tag  <= load_req.tag;
                        drop    <= flush;
                    end
                end
                st_setup: begin
                    state <= st_access;
                    if (flush) drop <= 1'b1;
                end
                default: begin
                    if (flush) drop <= 1'b1;
                    if (pready) begin
                        state <= st_idle;
                        if (pwrite) begin
                            cm.valid <= 1'b0;
                        end else begin
                            load_res.valid <= !drop && !flush;
                            load_res.tag   <= ld_tag;
                            load_res.addr  <= ld_addr;
                            load_res.data  <= ld_data;
                        end
                    end
                end
            endcase
        end
    end
endmodule

`default_nettype wire

/* design/dmem_apb.sv */
/*
 * Data RAM behind an APB slave port
 * Word wide, byte strobes, one wait state per access
 */
`default_nettype none
`include "lsq_defs.svh"

module dmem_apb import lsq_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  word_t      paddr,
    input  word_t      pwdata,
    input  logic [3:0] pstrb,
    output logic       pready,
    output word_t      prdata
);
    localparam int AW = $clog2(`LSQ_DMEM_WORDS);

    word_t         mem [`LSQ_DMEM_WORDS];
    logic [AW-1:0] idx;
    logic          waited;   // First access cycle seen

    assign idx    = paddr[AW+1:2];
    assign pready = psel && penable && waited;
    assign prdata = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            waited <= 1'b0;
            for (int i = 0; i < `LSQ_DMEM_WORDS; i++) mem[i] <= '0;
        end else begin
            waited <= psel && penable && !waited;
            if (pready && pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (pstrb[b]) mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end
endmodule

`default_nettype wire

/* design/lsb_top.sv */
/*
 * Load/store subsystem top level
 * Dispatch, reservation station, APB memory port and data RAM
 */
`default_nettype none
`include "lsq_defs.svh"

module lsb_top import lsq_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  dispatch_t     disp,
    output logic          dispatch_ready,
    input  cdb_t          cdb,
    input  store_commit_t commit,
    output logic          commit_ready,
    output lsb_result_t   store_res,
    output lsb_result_t   load_res
);
    lsb_entry_t entry;
    logic       entry_ready;
    load_req_t  load_req;
    logic       load_ready;
    logic       commit_fire;
    logic       psel;
    logic       penable;
    logic       pwrite;
    word_t      paddr;
    word_t      pwdata;
    logic [3:0] pstrb;
    logic       pready;
    word_t      prdata;

    assign commit_fire = commit.valid && commit_ready;

    lsb_dispatch u_dispatch (
        .clk(clk), .rst(rst), .flush(flush),
        .disp(disp), .dispatch_ready(dispatch_ready), .cdb(cdb),
        .entry(entry), .entry_ready(entry_ready)
    );

    lsb_rs u_rs (
        .clk(clk), .rst(rst), .flush(flush),
        .entry(entry), .entry_ready(entry_ready), .cdb(cdb),
        .commit_fire(commit_fire), .load_req(load_req), .load_ready(load_ready),
        .store_res(store_res)
    );

    lsb_mem_port u_mem_port (
        .clk(clk), .rst(rst), .flush(flush),
        .load_req(load_req), .load_ready(load_ready),
        .commit(commit), .commit_ready(commit_ready),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata),
        .load_res(load_res)
    );

    dmem_apb u_dmem (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata)
    );
endmodule

`default_nettype wire

/* dv/lsb_tb.sv */
/*
 * Testbench for the load/store subsystem
 * Clock and reset, ROB-like random dispatch, CDB, commit and flush stimulus,
 * byte-lane memory mirror and in-order operation list as reference model
 */
`default_nettype none
`include "lsq_defs.svh"

module lsb_tb import lsq_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPS = 220;
    localparam int LIMIT = 40 * N_OPS + 200;

    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
        tag_t       tag;
        word_t      addr;
        word_t      data;
        logic       done;
    } op_t;

    logic          clk = 1'b0;
    logic          rst;
    logic          flush;
    dispatch_t     disp;
    logic          dispatch_ready;
    cdb_t          cdb;
    store_commit_t commit;
    logic          commit_ready;
    lsb_result_t   store_res;
    lsb_result_t   load_res;

    op_t        inflight [$];   // Program order
    op_t        pend_op;        // Operation currently offered on disp
    tag_t       free_tags [$];
    logic [7:0] mirror [4*`LSQ_DMEM_WORDS];
    logic       busy [4];       // Producers 12..15 still owe a CDB value
    word_t      pval [4];
    int         errors;
    int         results;
    int         issued;
    int         flushed;
    int         cycles;
    int         gap;
    int         flush_k;
    logic       timed_out;
    logic       saw_stall;
    logic       disp_taken;
    logic       commit_taken;

    always #10 clk = ~clk;

    lsb_top u_lsb_top (
        .clk(clk), .rst(rst), .flush(flush),
        .disp(disp), .dispatch_ready(dispatch_ready), .cdb(cdb),
        .commit(commit), .commit_ready(commit_ready),
        .store_res(store_res), .load_res(load_res)
    );

    function automatic int find_op(tag_t t);
        for (int i = 0; i < inflight.size(); i++) begin
            if (inflight[i].tag == t) return i;
        end
        return -1;
    endfunction

    function automatic void write_mirror(word_t a, word_t d, logic [2:0] f3);
        int i;
        i = int'(a % (4 * `LSQ_DMEM_WORDS));
        mirror[i] = d[7:0];
        if (f3 != sb) mirror[i+1] = d[15:8];
        if (f3 == sw) begin
            mirror[i+2] = d[23:16];
            mirror[i+3] = d[31:24];
        end
    endfunction

    function automatic word_t expected_load(word_t a, logic [2:0] f3);
        int i;
        i = int'(a % (4 * `LSQ_DMEM_WORDS));
        case (f3)
            lb:      return {{24{mirror[i][7]}}, mirror[i]};
            lbu:     return {24'h0, mirror[i]};
            lh:      return {{16{mirror[i+1][7]}}, mirror[i+1], mirror[i]};
            lhu:     return {16'h0, mirror[i+1], mirror[i]};
            default: return {mirror[i+3], mirror[i+2], mirror[i+1], mirror[i]};
        endcase
    endfunction

    function automatic tag_t pick_producer();
        int p;
        p = int'($urandom % 4);
        if (!busy[p]) begin
            busy[p] = 1'b1;
            pval[p] = $urandom % 256;   // Small so it can serve as a base
        end
        return tag_t'(12 + p);
    endfunction

    task automatic new_op(input int pend_pct);
        logic       st;
        logic [2:0] f3;
        int         kind;
        word_t      addr;
        word_t      base;
        word_t      imm;
        word_t      data;
        tag_t       bt;
        tag_t       dt;
        st   = ($urandom % 2) != 0;
        kind = st ? int'($urandom % 3) : int'($urandom % 5);
        if (st) begin
            f3 = (kind == 0) ? sb : (kind == 1) ? sh : sw;
        end else begin
            case (kind)
                0:       f3 = lb;
                1:       f3 = lh;
                2:       f3 = lw;
                3:       f3 = lbu;
                default: f3 = lhu;
            endcase
        end
        addr = ($urandom % 4 == 0) ? ($urandom % 64) * 4 : ($urandom % 8) * 4;
        if (f3[1:0] == 2'b00) addr = addr + $urandom % 4;
        else if (f3[1:0] == 2'b01) addr = addr + ($urandom % 2) * 2;
        bt   = '0;
        base = $urandom % 256;
        if ($urandom % 100 < pend_pct) begin
            bt   = pick_producer();
            base = pval[int'(bt) - 12];
        end
        imm  = addr - base;   // Fits 12 bits signed
        dt   = '0;
        data = $urandom;
        if (st && $urandom % 100 < pend_pct) begin
            dt   = pick_producer();
            data = pval[int'(dt) - 12];
        end
        pend_op.is_store = st;
        pend_op.funct3   = f3;
        pend_op.tag      = free_tags.pop_front();
        pend_op.addr     = addr;
        pend_op.data     = data;
        pend_op.done     = 1'b0;
        disp.valid = 1'b1;
        if (st) begin
            disp.instr = {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], 7'b0100011};
        end else begin
            disp.instr = {imm[11:0], 5'($urandom), f3, 5'($urandom), 7'b0000011};
        end
        disp.base.tag   = bt;
        disp.base.value = (bt != '0) ? $urandom : base;   // Stale value while waiting
        disp.data.tag   = dt;
        disp.data.value = (dt != '0) ? $urandom : data;
        disp.dest       = pend_op.tag;
    endtask

    task automatic check_result(input lsb_result_t r, input logic is_store);
        int   idx;
        op_t  o;
        logic early;
        idx   = find_op(r.tag);
        early = 1'b0;
        if (idx < 0) begin
            errors++;
            $display("[FAIL] %0t: result for tag %0d with no operation in flight", $time, r.tag);
        end else begin
            o = inflight[idx];
            if (!is_store) begin
                for (int j = 0; j < idx; j++) begin
                    if (inflight[j].is_store) early = 1'b1;   // Older store still uncommitted
                end
            end
            if (o.is_store != is_store || o.done) begin
                errors++;
                $display("[FAIL] %0t: unexpected or repeated result for tag %0d", $time, r.tag);
            end else begin
                if (early) begin
                    errors++;
                    $display("[FAIL] %0t: load tag %0d returned ahead of an older store commit",
                             $time, r.tag);
                end
                if (r.addr != o.addr) begin
                    errors++;
                    $display("[FAIL] %0t: tag %0d address %h, expected %h",
                             $time, r.tag, r.addr, o.addr);
                end
                if (is_store && r.data != o.data) begin
                    errors++;
                    $display("[FAIL] %0t: store tag %0d data %h, expected %h",
                             $time, r.tag, r.data, o.data);
                end
                if (!is_store && r.data != expected_load(o.addr, o.funct3)) begin
                    errors++;
                    $display("[FAIL] %0t: load tag %0d funct3 %0d data %h, expected %h", $time,
                             r.tag, o.funct3, r.data, expected_load(o.addr, o.funct3));
                end
                o.done = 1'b1;
                inflight[idx] = o;
                results++;
            end
        end
    endtask

    // Outputs are stable at the falling edge; handshakes seen here fire at the next rise
    task automatic observe_outputs();
        op_t o;
        cycles++;
        if (cycles >= LIMIT) timed_out = 1'b1;
        disp_taken   = 1'b0;
        commit_taken = 1'b0;
        if (store_res.valid) check_result(store_res, 1'b1);
        if (load_res.valid) check_result(load_res, 1'b0);
        if (commit.valid && commit_ready) begin
            o = inflight.pop_front();
            write_mirror(o.addr, o.data, o.funct3);
            free_tags.push_back(o.tag);
            commit_taken = 1'b1;
        end
        if (disp.valid) begin
            if (dispatch_ready) begin
                inflight.push_back(pend_op);
                issued++;
                disp_taken = 1'b1;
            end else begin
                saw_stall = 1'b1;
            end
        end
        while (inflight.size() != 0 && !inflight[0].is_store && inflight[0].done) begin
            o = inflight.pop_front();   // Loads retire once done
            free_tags.push_back(o.tag);
        end
        if (flush) begin
            while (inflight.size() != 0) begin
                o = inflight.pop_front();
                free_tags.push_back(o.tag);
                flushed++;
            end
            gap = 6;
        end
    endtask

    task automatic drive_inputs();
        logic burst;
        logic flush_now;
        int   pend_pct;
        int   bcast_pct;
        int   start;
        int   p;
        burst     = (issued >= 20 && issued < 50) || (issued >= 110 && issued < 130);
        pend_pct  = burst ? 80 : 25;
        bcast_pct = burst ? 10 : 50;
        flush_now = (flush_k == 0 && issued >= 70) || (flush_k == 1 && issued >= 150);
        if (flush_now) flush_k++;
        flush = flush_now;
        if (gap > 0) gap--;
        if (commit_taken || flush_now) commit.valid = 1'b0;
        if (!commit.valid && !flush_now && inflight.size() != 0 && inflight[0].is_store &&
            inflight[0].done) begin
            commit.valid  = 1'b1;   // Head store with every older op done
            commit.addr   = inflight[0].addr;
            commit.data   = inflight[0].data;
            commit.funct3 = inflight[0].funct3;
        end
        if (disp_taken) disp.valid = 1'b0;
        if (flush_now && disp.valid) begin
            disp.valid = 1'b0;
            free_tags.push_back(pend_op.tag);
        end
        if (!disp.valid && !flush_now && gap == 0 && issued < N_OPS &&
            free_tags.size() != 0 && (burst || $urandom % 4 != 0)) begin
            new_op(pend_pct);
        end
        cdb = '0;
        if ($urandom % 100 < bcast_pct) begin
            start = int'($urandom % 4);
            for (int k = 0; k < 4; k++) begin
                p = (start + k) % 4;
                if (busy[p] && !cdb.valid) begin
                    cdb.valid = 1'b1;
                    cdb.tag   = tag_t'(12 + p);
                    cdb.value = pval[p];
                    busy[p]   = 1'b0;
                end
            end
            if (cdb.valid && disp.valid && disp.base.tag == cdb.tag) begin
                disp.base.tag   = '0;
                disp.base.value = cdb.value;
            end
            if (cdb.valid && disp.valid && disp.data.tag == cdb.tag) begin
                disp.data.tag   = '0;
                disp.data.value = cdb.value;
            end
        end
    endtask

    initial begin
        void'($urandom(23023));
        rst       = 1'b1;
        flush     = 1'b0;
        disp      = '0;
        cdb       = '0;
        commit    = '0;
        pend_op   = '0;
        errors    = 0;
        results   = 0;
        issued    = 0;
        flushed   = 0;
        cycles    = 0;
        gap       = 0;
        flush_k   = 0;
        timed_out = 1'b0;
        saw_stall = 1'b0;
        for (int i = 1; i <= 11; i++) free_tags.push_back(tag_t'(i));
        for (int i = 0; i < 4; i++) begin
            busy[i] = 1'b0;
            pval[i] = '0;
        end
        for (int i = 0; i < 4 * `LSQ_DMEM_WORDS; i++) mirror[i] = 8'h00;   // RAM resets to zero
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        while (!timed_out && (issued < N_OPS || inflight.size() != 0 || disp.valid)) begin
            @(negedge clk);
            observe_outputs();
            @(posedge clk);
            #1;
            drive_inputs();
        end
        if (timed_out) begin
            errors++;
            $display("Run stopped at the limit of %0d cycles with %0d operations still open",
                     LIMIT, inflight.size());
        end
        if (!saw_stall) begin
            errors++;
            $display("dispatch_ready never dropped during the operand bursts");
        end
        $display("Errors %0d, results %0d, issued %0d, flushed %0d, cycles %0d",
                 errors, results, issued, flushed, cycles);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/lsq_pkg.sv
design/lsb_dispatch.sv
design/lsb_rs.sv
design/lsb_mem_port.sv
design/dmem_apb.sv
design/lsb_top.sv
dv/lsb_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the load/store buffer testbench with Verilator
verilator --binary --timing -Wno-fatal -f compile.f --top-module lsb_tb -o lsb_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lsb_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
